// File: source/tau_pkg.sv
/*
 * Tensor address generator shared definitions
 * Lane and dimension sizes, offset and stride widths, and the packed
 * structs that carry offsets, stride and shuffle configuration and the
 * per-item sideband through the warp looper memory-offset stage
 */
package tau_pkg;

	// ====================
	// Sizes and widths
	// ====================

	// Vector lanes per work item
	localparam int VDIM = 2;
	// Tensor dimensions folded into the global address
	localparam int DIM = 3;
	// Width of one work offset
	localparam int WBW = 10;
	// Stride fraction and shift widths
	localparam int SF_BW = 4;
	localparam int SS_BW = 3;
	// Shuffle index selects one of DIM dimensions
	localparam int DIM_BW = 2;
	// Configuration id carried with the item
	localparam int NCFG_BW = 3;

	// ====================
	// Shared types
	// ====================

	// One offset per vector lane
	typedef logic [VDIM-1:0][WBW-1:0] lane_ofs_t;

	// One offset per tensor dimension
	typedef logic [DIM-1:0][WBW-1:0] dim_ofs_t;

	// Stride as frac * 2**shamt, per lane
	typedef struct packed {
		logic [VDIM-1:0][SF_BW-1:0] frac;
		logic [VDIM-1:0][SS_BW-1:0] shamt;
	} stride_cfg_t;

	// Target dimension of each lane, block and warp side
	typedef struct packed {
		logic [VDIM-1:0][DIM_BW-1:0] bshuf;
		logic [VDIM-1:0][DIM_BW-1:0] ashuf;
	} shuf_cfg_t;

	// Sideband that rides along with the item untouched
	typedef struct packed {
		logic [NCFG_BW-1:0] id;
		logic               retire;
		logic               islast;
	} item_tag_t;

endpackage

// File: source/rdyack_stage.sv
/*
 * Forward register stage on the ready/ack handshake
 * Holds one payload and a full flag, and accepts a new item
 * whenever it is empty or its held item leaves in the same cycle
 */
`timescale 1ns/1ps

module rdyack_stage #(
	parameter int BW = 8
) (
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  logic          i_src_rdy,
	output logic          o_src_ack,
	input  logic [BW-1:0] i_src_data,
	output logic          o_dst_rdy,
	input  logic          i_dst_ack,
	output logic [BW-1:0] o_dst_data
);

	logic full_r;
	logic slot_free;

	// Room for a new item when empty or when draining now
	assign slot_free = !full_r || i_dst_ack;
	assign o_src_ack = i_src_rdy && slot_free;
	// Valid towards the next stage while holding an item
	assign o_dst_rdy = full_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			full_r     <= 1'b0;
			o_dst_data <= '0;
		end else if (o_src_ack) begin
			// Load overrides drain, stage stays full
			full_r     <= 1'b1;
			o_dst_data <= i_src_data;
		end else if (i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

endmodule

// File: source/stride_scaler.sv
/*
 * Lane stride scaler
 * Multiplies every lane offset by its stride fraction and shifts the
 * product left by the stride shift, wrapping to the offset width
 * Purely combinational, one instance per offset kind
 */
`timescale 1ns/1ps

module stride_scaler (
	input  tau_pkg::lane_ofs_t   i_ofs,
	input  tau_pkg::stride_cfg_t i_stride,
	output tau_pkg::lane_ofs_t   o_scaled
);

	// ====================
	// Local widths
	// ====================

	// Full product of offset and fraction
	localparam int PBW = tau_pkg::WBW + tau_pkg::SF_BW;

	// ====================
	// Per-lane scaling
	// ====================

	logic [tau_pkg::VDIM-1:0][PBW-1:0]          prod;
	logic [tau_pkg::VDIM-1:0][tau_pkg::WBW-1:0] prod_trunc;

	always_comb begin
		for (int l = 0; l < tau_pkg::VDIM; l++) begin
			// Exact product first
			prod[l] = PBW'(i_ofs[l]) * PBW'(i_stride.frac[l]);
			// Upper product bits fall off the offset width anyway
			prod_trunc[l] = prod[l][tau_pkg::WBW-1:0];
			// Power-of-two part of the stride
			o_scaled[l] = prod_trunc[l] << i_stride.shamt[l];
		end
	end

endmodule

// File: source/shuf_accum.sv
/*
 * Shuffle accumulator
 * Scatters the scaled block and warp lane offsets into tensor
 * dimensions by their shuffle indices and sums each dimension
 * Dimensions that no lane selects come out as zero
 */
`timescale 1ns/1ps

module shuf_accum (
	input  tau_pkg::lane_ofs_t i_bscaled,
	input  tau_pkg::lane_ofs_t i_ascaled,
	input  tau_pkg::shuf_cfg_t i_shuf,
	output tau_pkg::dim_ofs_t  o_dim
);

	// ====================
	// Lane selects
	// ====================

	// One hit bit per dimension and lane
	logic [tau_pkg::DIM-1:0][tau_pkg::VDIM-1:0] bhit;
	logic [tau_pkg::DIM-1:0][tau_pkg::VDIM-1:0] ahit;

	always_comb begin
		for (int d = 0; d < tau_pkg::DIM; d++) begin
			for (int l = 0; l < tau_pkg::VDIM; l++) begin
				bhit[d][l] = i_shuf.bshuf[l] == tau_pkg::DIM_BW'(d);
				ahit[d][l] = i_shuf.ashuf[l] == tau_pkg::DIM_BW'(d);
			end
		end
	end

	// ====================
	// Dimension sums
	// ====================

	always_comb begin
		for (int d = 0; d < tau_pkg::DIM; d++) begin
			o_dim[d] = '0;
			for (int l = 0; l < tau_pkg::VDIM; l++) begin
				// Several lanes may land on the same dimension
				if (bhit[d][l]) begin
					o_dim[d] = o_dim[d] + i_bscaled[l];
				end
				if (ahit[d][l]) begin
					o_dim[d] = o_dim[d] + i_ascaled[l];
				end
			end
		end
	end

endmodule

// File: source/memofs_linearizer.sv
/*
 * Memory offset linearizer
 * Two forward stages on the ready/ack handshake
 * The first registers the dimension offsets, boundary multipliers,
 * base address and sideband, the second registers the folded
 * linear address together with the passed-through bofs and tag
 */
`timescale 1ns/1ps

module memofs_linearizer #(
	parameter int ABW = 16
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_src_rdy,
	output logic                                  o_src_ack,
	input  tau_pkg::dim_ofs_t                     i_dim,
	input  tau_pkg::item_tag_t                    i_tag,
	input  tau_pkg::lane_ofs_t                    i_bofs,
	input  logic [ABW-1:0]                        i_linear,
	input  logic [tau_pkg::DIM-1:0][ABW-1:0]      i_mboundary,
	output logic                                  o_dst_rdy,
	input  logic                                  i_dst_ack,
	output tau_pkg::item_tag_t                    o_tag,
	output tau_pkg::lane_ofs_t                    o_bofs,
	output logic [ABW-1:0]                        o_linear
);

	// ====================
	// Stage payloads
	// ====================

	// Everything the fold needs, held in stage 0
	typedef struct packed {
		tau_pkg::dim_ofs_t                  dim;
		logic [tau_pkg::DIM-2:0][ABW-1:0]   mult;
		logic [ABW-1:0]                     linear;
		tau_pkg::lane_ofs_t                 bofs;
		tau_pkg::item_tag_t                 tag;
	} s0_pay_t;

	// Final result held in stage 1
	typedef struct packed {
		logic [ABW-1:0]     linear;
		tau_pkg::lane_ofs_t bofs;
		tau_pkg::item_tag_t tag;
	} s1_pay_t;

	s0_pay_t s0_d;
	s0_pay_t s0_q;
	s1_pay_t s1_d;
	s1_pay_t s1_q;
	logic    s0_rdy;
	logic    s0_ack;

	// Stage 0 input, multiplier d is the boundary of dimension d+1
	always_comb begin
		s0_d.dim    = i_dim;
		s0_d.linear = i_linear;
		s0_d.bofs   = i_bofs;
		s0_d.tag    = i_tag;
		for (int d = 0; d < tau_pkg::DIM-1; d++) begin
			s0_d.mult[d] = i_mboundary[d+1];
		end
	end

	// Fold from the stage 0 registers, wraps modulo 2**ABW
	always_comb begin
		s1_d.linear = s0_q.linear + ABW'(s0_q.dim[tau_pkg::DIM-1]);
		for (int d = 0; d < tau_pkg::DIM-1; d++) begin
			// Offsets are unsigned, zero extended
			s1_d.linear = s1_d.linear + ABW'(s0_q.dim[d]) * s0_q.mult[d];
		end
		s1_d.bofs = s0_q.bofs;
		s1_d.tag  = s0_q.tag;
	end

	// ====================
	// Forward stages
	// ====================

	rdyack_stage #(.BW($bits(s0_pay_t))) u_stage0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (i_src_rdy),
		.o_src_ack  (o_src_ack),
		.i_src_data (s0_d),
		.o_dst_rdy  (s0_rdy),
		.i_dst_ack  (s0_ack),
		.o_dst_data (s0_q)
	);

	rdyack_stage #(.BW($bits(s1_pay_t))) u_stage1 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (s0_rdy),
		.o_src_ack  (s0_ack),
		.i_src_data (s1_d),
		.o_dst_rdy  (o_dst_rdy),
		.i_dst_ack  (i_dst_ack),
		.o_dst_data (s1_q)
	);

	// Unpack the held result
	assign o_linear = s1_q.linear;
	assign o_bofs   = s1_q.bofs;
	assign o_tag    = s1_q.tag;

endmodule

// File: source/warp_memofs_top.sv
/*
 * Warp looper memory-offset stage
 * Scales block and warp lane offsets by their strides, scatters them
 * into tensor dimensions and folds those into one global address
 */
`timescale 1ns/1ps

module warp_memofs_top #(
	parameter int ABW = 16
) (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	// Source side
	input  logic                             i_src_rdy,
	output logic                             o_src_ack,
	input  tau_pkg::item_tag_t               i_tag,
	input  tau_pkg::lane_ofs_t               i_bofs,
	input  tau_pkg::lane_ofs_t               i_aofs,
	input  logic [ABW-1:0]                   i_linear,
	input  tau_pkg::stride_cfg_t             i_bstride,
	input  tau_pkg::stride_cfg_t             i_astride,
	input  tau_pkg::shuf_cfg_t               i_shuf,
	input  logic [tau_pkg::DIM-1:0][ABW-1:0] i_mboundary,
	// Destination side
	output logic                             o_dst_rdy,
	input  logic                             i_dst_ack,
	output tau_pkg::item_tag_t               o_tag,
	output tau_pkg::lane_ofs_t               o_bofs,
	output logic [ABW-1:0]                   o_linear
);

	tau_pkg::lane_ofs_t bscaled;
	tau_pkg::lane_ofs_t ascaled;
	tau_pkg::dim_ofs_t  dim;

	// Block offsets
	stride_scaler u_bscale (
		.i_ofs    (i_bofs),
		.i_stride (i_bstride),
		.o_scaled (bscaled)
	);

	// Warp offsets
	stride_scaler u_ascale (
		.i_ofs    (i_aofs),
		.i_stride (i_astride),
		.o_scaled (ascaled)
	);

	shuf_accum u_accum (
		.i_bscaled (bscaled),
		.i_ascaled (ascaled),
		.i_shuf    (i_shuf),
		.o_dim     (dim)
	);

	// All state and flow control live here
	memofs_linearizer #(.ABW(ABW)) u_lin (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_src_rdy   (i_src_rdy),
		.o_src_ack   (o_src_ack),
		.i_dim       (dim),
		.i_tag       (i_tag),
		.i_bofs      (i_bofs),
		.i_linear    (i_linear),
		.i_mboundary (i_mboundary),
		.o_dst_rdy   (o_dst_rdy),
		.i_dst_ack   (i_dst_ack),
		.o_tag       (o_tag),
		.o_bofs      (o_bofs),
		.o_linear    (o_linear)
	);

endmodule

// File: tests/memofs_properties.sv
/*
 * Linearizer handshake properties
 * Bound into every memofs_linearizer, watches ack against rdy,
 * the reset state of the output and the hold under back-pressure
 */
`timescale 1ns/1ps

module memofs_properties #(
	parameter int ABW = 16
) (
	input logic                    i_clk,
	input logic                    i_rst_n,
	input logic                    i_src_rdy,
	input logic                    i_src_ack,
	input logic                    i_dst_rdy,
	input logic                    i_dst_ack,
	input tau_pkg::item_tag_t      i_tag,
	input tau_pkg::lane_ofs_t      i_bofs,
	input logic [ABW-1:0]          i_linear
);

	// Failed property evaluations so far
	int fail_cnt;

	// ====================
	// Flow control
	// ====================

	// Source side only held off while both stages are full and stalled
	src_ack_only_stalled: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_src_rdy && !i_src_ack) |-> (i_dst_rdy && !i_dst_ack)
	) else begin
		$error("source ack withheld with the output not stalled");
		fail_cnt++;
	end

	// Destination side ack only with a held item
	dst_ack_with_rdy: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) i_dst_ack |-> i_dst_rdy
	) else begin
		$error("destination ack raised without destination rdy");
		fail_cnt++;
	end

	// Nothing held straight out of reset
	rdy_low_after_reset: assert property (
		@(posedge i_clk) !i_rst_n |=> !i_dst_rdy
	) else begin
		$error("destination rdy high right after reset");
		fail_cnt++;
	end

	// Stalled result stays put until taken
	hold_under_stall: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_dst_rdy && !i_dst_ack) |=>
		(i_dst_rdy && $stable(i_linear) && $stable(i_bofs) && $stable(i_tag))
	) else begin
		$error("held output changed while stalled");
		fail_cnt++;
	end

endmodule

bind memofs_linearizer memofs_properties #(.ABW(ABW)) u_props (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_src_rdy (i_src_rdy),
	.i_src_ack (o_src_ack),
	.i_dst_rdy (o_dst_rdy),
	.i_dst_ack (i_dst_ack),
	.i_tag     (o_tag),
	.i_bofs    (o_bofs),
	.i_linear  (o_linear)
);

// File: tests/tb_warp_memofs.sv
/*
 * Warp looper memory-offset stage testbench
 * Applies a 16-entry item table, first with continuous ack and then
 * with LFSR-driven back-pressure, and checks every result in order
 */
`timescale 1ns/1ps

module tb_warp_memofs;

	localparam int ABW     = 16;
	localparam int NITEMS  = 16;
	localparam int TIMEOUT = NITEMS * 8 + 40;

	// One table row of stimulus
	typedef struct packed {
		tau_pkg::item_tag_t               tag;
		tau_pkg::lane_ofs_t               bofs;
		tau_pkg::lane_ofs_t               aofs;
		tau_pkg::stride_cfg_t             bstr;
		tau_pkg::stride_cfg_t             astr;
		tau_pkg::shuf_cfg_t               shuf;
		logic [tau_pkg::DIM-1:0][ABW-1:0] bnd;
		logic [ABW-1:0]                   base;
	} stim_t;

	// Expected result plus the cycle it went in
	typedef struct packed {
		logic [ABW-1:0]     linear;
		tau_pkg::lane_ofs_t bofs;
		tau_pkg::item_tag_t tag;
		logic [31:0]        cyc;
	} result_t;

	logic                             i_clk;
	logic                             i_rst_n;
	logic                             i_src_rdy;
	logic                             o_src_ack;
	tau_pkg::item_tag_t               i_tag;
	tau_pkg::lane_ofs_t               i_bofs;
	tau_pkg::lane_ofs_t               i_aofs;
	logic [ABW-1:0]                   i_linear;
	tau_pkg::stride_cfg_t             i_bstride;
	tau_pkg::stride_cfg_t             i_astride;
	tau_pkg::shuf_cfg_t               i_shuf;
	logic [tau_pkg::DIM-1:0][ABW-1:0] i_mboundary;
	logic                             o_dst_rdy;
	logic                             i_dst_ack;
	tau_pkg::item_tag_t               o_tag;
	tau_pkg::lane_ofs_t               o_bofs;
	logic [ABW-1:0]                   o_linear;

	stim_t       tbl [NITEMS];
	result_t     tbl_exp [NITEMS];
	result_t     exp_q [$];
	logic [31:0] lfsr;
	int          cycles;
	int          err_val;
	int          err_flow;
	int          err_prop;
	int          n_acc;
	int          n_out;

	warp_memofs_top #(.ABW(ABW)) u_dut (.*);

	always #10 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT) begin
			$display("Timeout after %0d cycles, %0d of %0d items came out", cycles, n_out, NITEMS);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ====================
	// Random source
	// ====================

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// ====================
	// Reference model
	// ====================

	// Offset times frac times 2**shamt, wrapped to the offset width
	function automatic int unsigned scale_lane(input int unsigned ofs, input int unsigned frac,
			input int unsigned shamt);
		return ((ofs * frac) << shamt) % (1 << tau_pkg::WBW);
	endfunction

	function automatic logic [ABW-1:0] expect_linear(input stim_t s);
		int unsigned bsc [tau_pkg::VDIM];
		int unsigned asc [tau_pkg::VDIM];
		int unsigned dsum [tau_pkg::DIM];
		int unsigned acc;
		for (int l = 0; l < tau_pkg::VDIM; l++) begin
			bsc[l] = scale_lane(s.bofs[l], s.bstr.frac[l], s.bstr.shamt[l]);
			asc[l] = scale_lane(s.aofs[l], s.astr.frac[l], s.astr.shamt[l]);
		end
		// Scatter by shuffle index, unselected dims stay zero
		for (int d = 0; d < tau_pkg::DIM; d++) begin
			dsum[d] = 0;
			for (int l = 0; l < tau_pkg::VDIM; l++) begin
				if (s.shuf.bshuf[l] == d) dsum[d] += bsc[l];
				if (s.shuf.ashuf[l] == d) dsum[d] += asc[l];
			end
			dsum[d] = dsum[d] % (1 << tau_pkg::WBW);
		end
		acc = s.base + dsum[tau_pkg::DIM-1];
		for (int d = 0; d < tau_pkg::DIM-1; d++) begin
			acc += dsum[d] * s.bnd[d+1];
		end
		return acc % (1 << ABW);
	endfunction

	// ====================
	// Table setup
	// ====================

	task automatic fill_entry(input int i);
		logic [31:0] r;
		for (int l = 0; l < tau_pkg::VDIM; l++) begin
			draw_bits(2 * tau_pkg::WBW, r);
			tbl[i].bofs[l] = r[9:0];
			tbl[i].aofs[l] = r[19:10];
			// Fractions in the low byte, shifts above
			draw_bits(14, r);
			tbl[i].bstr.frac[l]  = r[3:0];
			tbl[i].astr.frac[l]  = r[7:4];
			tbl[i].bstr.shamt[l] = r[10:8];
			tbl[i].astr.shamt[l] = r[13:11];
			draw_bits(4, r);
			tbl[i].shuf.bshuf[l] = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
			tbl[i].shuf.ashuf[l] = (r[3:2] == 2'd3) ? 2'd0 : r[3:2];
		end
		for (int d = 0; d < tau_pkg::DIM; d++) begin
			draw_bits(ABW, r);
			tbl[i].bnd[d] = r[ABW-1:0];
		end
		draw_bits(ABW, r);
		tbl[i].base = r[ABW-1:0];
		draw_bits($bits(tau_pkg::item_tag_t), r);
		tbl[i].tag = r[$bits(tau_pkg::item_tag_t)-1:0];
		// Identity shuffle on the first four
		if (i < 4) begin
			tbl[i].shuf.bshuf = {2'd1, 2'd0};
			tbl[i].shuf.ashuf = {2'd1, 2'd0};
		end else if (i < 8) begin
			// Lanes pair up, dim i%3 left empty
			tbl[i].shuf.bshuf = {2{2'((i + 1) % 3)}};
			tbl[i].shuf.ashuf = {2{2'((i + 2) % 3)}};
		end
	endtask

	task automatic apply_item(input stim_t s);
		i_tag       = s.tag;
		i_bofs      = s.bofs;
		i_aofs      = s.aofs;
		i_bstride   = s.bstr;
		i_astride   = s.astr;
		i_shuf      = s.shuf;
		i_mboundary = s.bnd;
		i_linear    = s.base;
	endtask

	task automatic check_result(input result_t e, input int idx);
		assert (o_linear == e.linear) else begin
			$display("ERR o_linear item %0d exp %h got %h", idx, e.linear, o_linear);
			err_val++;
		end
		assert (o_bofs == e.bofs) else begin
			$display("ERR o_bofs item %0d exp %h got %h", idx, e.bofs, o_bofs);
			err_val++;
		end
		assert (o_tag == e.tag) else begin
			$display("ERR o_tag item %0d exp %h got %h", idx, e.tag, o_tag);
			err_val++;
		end
		// Continuous-ack half, two edges from acceptance
		if (idx < NITEMS / 2) begin
			assert (cycles - e.cyc == 2) else begin
				$display("Item %0d came out %0d cycles after acceptance", idx, cycles - e.cyc);
				err_flow++;
			end
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		logic [31:0] r;
		result_t     e;
		int          held;
		logic        exp_ack;
		i_clk     = 1'b0;
		i_rst_n   = 1'b0;
		i_src_rdy = 1'b0;
		i_dst_ack = 1'b0;
		apply_item('0);
		lfsr     = 32'h6494;
		cycles   = 0;
		err_val  = 0;
		err_flow = 0;
		err_prop = 0;
		n_acc    = 0;
		n_out    = 0;
		for (int i = 0; i < NITEMS; i++) begin
			fill_entry(i);
		end
		// Entry 0 wraps lane 0 hard
		tbl[0].bofs[0]       = 10'h3FF;
		tbl[0].bstr.frac[0]  = 4'hF;
		tbl[0].bstr.shamt[0] = 3'd7;
		for (int i = 0; i < NITEMS; i++) begin
			tbl_exp[i] = '{linear: expect_linear(tbl[i]), bofs: tbl[i].bofs,
				tag: tbl[i].tag, cyc: 0};
		end

		// Reset for 10 edges, ack follows rdy in the last two
		repeat (8) @(posedge i_clk);
		#2 i_src_rdy = 1'b1;
		@(negedge i_clk);
		assert (o_src_ack == 1'b1 && o_dst_rdy == 1'b0) else begin
			$display("ERR o_src_ack exp 1 got %h, o_dst_rdy exp 0 got %h", o_src_ack, o_dst_rdy);
			err_val++;
		end
		@(posedge i_clk);
		#2 i_src_rdy = 1'b0;
		@(negedge i_clk);
		assert (o_src_ack == 1'b0) else begin
			$display("ERR o_src_ack exp 0 got %h", o_src_ack);
			err_val++;
		end
		@(posedge i_clk);
		#2 i_rst_n = 1'b1;
		@(negedge i_clk);
		assert (o_dst_rdy == 1'b0 && o_linear == '0) else begin
			$display("ERR after reset o_dst_rdy %h o_linear %h, both exp 0", o_dst_rdy, o_linear);
			err_val++;
		end

		while (n_out < NITEMS) begin
			@(posedge i_clk);
			#2;
			if (n_acc < NITEMS) begin
				apply_item(tbl[n_acc]);
				i_src_rdy = 1'b1;
			end else begin
				i_src_rdy = 1'b0;
			end
			// Second half sees random stalls
			if (n_out < NITEMS / 2) begin
				i_dst_ack = o_dst_rdy;
			end else begin
				draw_bits(1, r);
				i_dst_ack = o_dst_rdy && r[0];
			end
			@(negedge i_clk);
			held    = n_acc - n_out;
			exp_ack = i_src_rdy && !(held == 2 && !i_dst_ack);
			assert (o_src_ack == exp_ack) else begin
				$display("ERR o_src_ack exp %h got %h with %0d held", exp_ack, o_src_ack, held);
				err_flow++;
			end
			if (o_dst_rdy && i_dst_ack) begin
				assert (exp_q.size() > 0) else begin
					$display("Output transfer with no item outstanding");
					err_flow++;
				end
				if (exp_q.size() > 0) begin
					e = exp_q.pop_front();
					check_result(e, n_out);
				end
				n_out++;
			end
			if (i_src_rdy && o_src_ack) begin
				e     = tbl_exp[n_acc];
				e.cyc = cycles;
				exp_q.push_back(e);
				n_acc++;
			end
		end

		// Pipeline must be empty now
		@(posedge i_clk);
		#2 i_dst_ack = 1'b0;
		@(negedge i_clk);
		assert (!o_dst_rdy && exp_q.size() == 0) else begin
			$display("Extra item left in the pipeline after the last result");
			err_flow++;
		end

		// Failures of the bound handshake properties
		err_prop = u_dut.u_lin.u_props.fail_cnt;

		$display("Summary: %0d of %0d items out, %0d value, %0d flow, %0d property errors",
			n_out, NITEMS, err_val, err_flow, err_prop);
		if (err_val + err_flow + err_prop == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: project.f
source/tau_pkg.sv
source/rdyack_stage.sv
source/stride_scaler.sv
source/shuf_accum.sv
source/memofs_linearizer.sv
source/warp_memofs_top.sv
tests/memofs_properties.sv
tests/tb_warp_memofs.sv
